/* logic/oramPkg.sv */
// Tree geometry constants for the Path ORAM
// Shared types for client, backend, stash and DRAM traffic
`default_nettype none

package oramPkg;

	// ------------------------------------------------------------------------
	// Tree geometry
	// ------------------------------------------------------------------------

	localparam int OramLevels = 4;
	localparam int OramZ = 2;
	localparam int NumBlocks = 16;
	localparam int PathSlots = OramLevels * OramZ;

	typedef logic [$clog2(NumBlocks)-1:0] addrT;
	typedef logic [OramLevels-2:0] leafT;
	typedef logic [31:0] dataT;

	// Slot address is bucket * OramZ + slot
	typedef logic [4:0] dramAddrT;

	// ------------------------------------------------------------------------
	// Structs
	// ------------------------------------------------------------------------

	// One DRAM word, also a stash entry
	typedef struct packed {
		logic valid;
		addrT addr;
		leafT leaf;
		dataT data;
	} slotT;

	typedef struct packed {
		logic write;
		addrT addr;
		dataT data;
	} oramCmdT;

	// Request handed from frontend to backend
	typedef struct packed {
		logic write;
		addrT addr;
		leafT oldLeaf;
		leafT newLeaf;
		dataT data;
	} beReqT;

	typedef struct packed {
		logic write;
		dramAddrT addr;
	} dramCmdT;

endpackage

`default_nettype wire

/* logic/readBuffer.sv */
// Circular FIFO for DRAM read data, which arrives without back-pressure
`timescale 1ns/1ps
`default_nettype none

module readBuffer #(
	parameter int BufDepth = 8
) (
	input  logic          Clock,
	input  logic          rstN,
	input  oramPkg::slotT inData,
	input  logic          inValid,
	output oramPkg::slotT outData,
	output logic          outValid,
	input  logic          outReady
);
	import oramPkg::*;

	localparam int PtrW = $clog2(BufDepth);
	localparam int CntW = $clog2(BufDepth + 1);

	slotT mem [BufDepth];
	logic [PtrW-1:0] wrPtr;
	logic [PtrW-1:0] rdPtr;
	logic [CntW-1:0] count;
	logic pop;

	assign outValid = (count != '0);
	assign outData = mem[rdPtr];
	assign pop = outValid && outReady;

	always_ff @(posedge Clock or negedge rstN) begin
		if (!rstN) begin
			wrPtr <= '0;
			rdPtr <= '0;
			count <= '0;
		end else begin
			if (inValid) begin
				wrPtr <= (wrPtr == PtrW'(BufDepth - 1)) ? '0 : wrPtr + 1'b1;
			end
			if (pop) begin
				rdPtr <= (rdPtr == PtrW'(BufDepth - 1)) ? '0 : rdPtr + 1'b1;
			end
			case ({inValid, pop})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	// Outstanding reads never exceed the depth
	always_ff @(posedge Clock) begin
		if (inValid) begin
			mem[wrPtr] <= inData;
		end
	end

endmodule

`default_nettype wire

/* logic/oramStash.sv */
// Stash storage with address lookup, insertion and in-place update
// Eviction selection by path prefix with lowest-index priority
`timescale 1ns/1ps
`default_nettype none

module oramStash #(
	parameter int StashCap = 16
) (
	input  logic                                  Clock,
	input  logic                                  rstN,
	input  logic                                  insValid,
	input  oramPkg::slotT                         insSlot,
	input  oramPkg::addrT                         findAddr,
	output logic                                  findHit,
	output oramPkg::slotT                         findSlot,
	input  logic                                  updValid,
	input  oramPkg::slotT                         updSlot,
	input  logic [$clog2(oramPkg::OramLevels)-1:0] evLevel,
	input  oramPkg::leafT                         evLeaf,
	output logic                                  evHit,
	output oramPkg::slotT                         evSlot,
	input  logic                                  evTake
);
	import oramPkg::*;

	localparam int IdxW = $clog2(StashCap);

	slotT entries [StashCap];
	logic [StashCap-1:0] used;

	logic [IdxW-1:0] findIdx;
	logic [IdxW-1:0] evIdx;
	logic [IdxW-1:0] freeIdx;
	logic freeHit;

	// ------------------------------------------------------------------------
	// Combinational selection
	// ------------------------------------------------------------------------

	// Address lookup, lowest index wins
	always_comb begin
		findHit = 1'b0;
		findIdx = '0;
		for (int i = StashCap - 1; i >= 0; i--) begin
			if (used[i] && entries[i].addr == findAddr) begin
				findHit = 1'b1;
				findIdx = IdxW'(i);
			end
		end
	end

	assign findSlot = entries[findIdx];

	// A block fits a bucket when its leaf shares the path down to that level
	always_comb begin
		int shift;
		shift = OramLevels - 1 - int'(evLevel);
		evHit = 1'b0;
		evIdx = '0;
		for (int i = StashCap - 1; i >= 0; i--) begin
			if (used[i] && (entries[i].leaf >> shift) == (evLeaf >> shift)) begin
				evHit = 1'b1;
				evIdx = IdxW'(i);
			end
		end
	end

	assign evSlot = entries[evIdx];

	// First free entry for insertion
	always_comb begin
		freeHit = 1'b0;
		freeIdx = '0;
		for (int i = StashCap - 1; i >= 0; i--) begin
			if (!used[i]) begin
				freeHit = 1'b1;
				freeIdx = IdxW'(i);
			end
		end
	end

	// ------------------------------------------------------------------------
	// Storage
	// ------------------------------------------------------------------------

	always_ff @(posedge Clock or negedge rstN) begin
		if (!rstN) begin
			used <= '0;
		end else begin
			if (insValid && freeHit) begin
				used[freeIdx] <= 1'b1;
			end
			if (evTake && evHit) begin
				used[evIdx] <= 1'b0;
			end
		end
	end

	always_ff @(posedge Clock) begin
		if (insValid && freeHit) begin
			entries[freeIdx] <= insSlot;
		end
		if (updValid && findHit) begin
			entries[findIdx] <= updSlot;
		end
	end

endmodule

`default_nettype wire

/* logic/pathBackend.sv */
// Path read, block service and write-back FSM toward DRAM
// Heap addressing of the path buckets and the stash instance
`timescale 1ns/1ps
`default_nettype none

module pathBackend #(
	parameter int StashCap = 16
) (
	input  logic             Clock,
	input  logic             rstN,
	input  oramPkg::beReqT   beReq,
	input  logic             reqValid,
	output logic             reqReady,
	output oramPkg::dataT    loadData,
	output logic             loadValid,
	input  logic             loadReady,
	input  oramPkg::slotT    bufData,
	input  logic             bufValid,
	output logic             bufReady,
	output oramPkg::dramCmdT dramCmd,
	output logic             dramCmdValid,
	input  logic             dramCmdReady,
	output oramPkg::slotT    dramWriteData,
	output logic             dramWriteDataValid,
	input  logic             dramWriteDataReady
);
	import oramPkg::*;

	localparam int IdxW = $clog2(PathSlots + 1);
	localparam int LvlW = $clog2(OramLevels);

	typedef enum logic [2:0] {
		stIdle,
		stReadPath,
		stService,
		stReturn,
		stWritePath
	} stateT;

	stateT state;
	beReqT req;
	logic [IdxW-1:0] rdCmdIdx;
	logic [IdxW-1:0] rdDataIdx;
	logic [IdxW-1:0] wrIdx;
	logic wrLoaded;
	logic cmdSent;
	logic dataSent;
	slotT wrSlot;

	logic insValid;
	slotT insSlot;
	logic updValid;
	slotT svcSlot;
	logic findHit;
	slotT findSlot;
	logic [LvlW-1:0] evLevel;
	logic evHit;
	slotT evSlot;
	logic evTake;

	logic wrPick;
	logic cmdFire;
	logic dataFire;
	logic slotDone;
	logic bufFire;

	// Bucket on the leaf's path at a level, in heap order
	function automatic dramAddrT slotAddr(leafT leaf, int level, int slot);
		int bucket;
		bucket = (1 << level) - 1 + int'(leaf >> (OramLevels - 1 - level));
		return dramAddrT'(bucket * OramZ + slot);
	endfunction

	// ------------------------------------------------------------------------
	// Handshakes and DRAM outputs
	// ------------------------------------------------------------------------

	assign reqReady = (state == stIdle);
	assign bufReady = (state == stReadPath);
	assign bufFire = bufValid && bufReady;
	assign loadValid = (state == stReturn);

	assign wrPick = (state == stWritePath) && !wrLoaded;
	assign dramWriteDataValid = (state == stWritePath) && wrLoaded && !dataSent;
	assign dramWriteData = wrSlot;

	always_comb begin
		dramCmdValid = 1'b0;
		dramCmd.write = 1'b0;
		dramCmd.addr = slotAddr(req.oldLeaf, int'(rdCmdIdx) / OramZ, int'(rdCmdIdx) % OramZ);
		if (state == stReadPath) begin
			dramCmdValid = (rdCmdIdx < IdxW'(PathSlots));
		end else if (state == stWritePath) begin
			// Leaf to root on write-back
			dramCmdValid = wrLoaded && !cmdSent;
			dramCmd.write = 1'b1;
			dramCmd.addr = slotAddr(req.oldLeaf, OramLevels - 1 - int'(wrIdx) / OramZ,
				int'(wrIdx) % OramZ);
		end
	end

	assign cmdFire = dramCmdValid && dramCmdReady;
	assign dataFire = dramWriteDataValid && dramWriteDataReady;
	assign slotDone = wrLoaded && (cmdSent || cmdFire) && (dataSent || dataFire);

	// ------------------------------------------------------------------------
	// Stash control
	// ------------------------------------------------------------------------

	always_comb begin
		svcSlot.valid = 1'b1;
		svcSlot.addr = req.addr;
		svcSlot.leaf = req.newLeaf;
		// Absent block reads as zero
		svcSlot.data = req.write ? req.data : (findHit ? findSlot.data : '0);
	end

	assign insValid = (bufFire && bufData.valid) || (state == stService && !findHit);
	assign insSlot = (state == stService) ? svcSlot : bufData;
	assign updValid = (state == stService) && findHit;
	assign evLevel = LvlW'(OramLevels - 1 - int'(wrIdx) / OramZ);
	assign evTake = wrPick && evHit;

	oramStash #(
		.StashCap(StashCap)
	) stash0 (
		.Clock(Clock),
		.rstN(rstN),
		.insValid(insValid),
		.insSlot(insSlot),
		.findAddr(req.addr),
		.findHit(findHit),
		.findSlot(findSlot),
		.updValid(updValid),
		.updSlot(svcSlot),
		.evLevel(evLevel),
		.evLeaf(req.oldLeaf),
		.evHit(evHit),
		.evSlot(evSlot),
		.evTake(evTake)
	);

	// ------------------------------------------------------------------------
	// FSM
	// ------------------------------------------------------------------------

	always_ff @(posedge Clock or negedge rstN) begin
		if (!rstN) begin
			state <= stIdle;
			rdCmdIdx <= '0;
			rdDataIdx <= '0;
			wrIdx <= '0;
			wrLoaded <= 1'b0;
			cmdSent <= 1'b0;
			dataSent <= 1'b0;
		end else begin
			case (state)
				stIdle: begin
					rdCmdIdx <= '0;
					rdDataIdx <= '0;
					wrIdx <= '0;
					if (reqValid) begin
						state <= stReadPath;
					end
				end
				stReadPath: begin
					if (cmdFire) begin
						rdCmdIdx <= rdCmdIdx + 1'b1;
					end
					if (bufFire) begin
						rdDataIdx <= rdDataIdx + 1'b1;
						if (rdDataIdx == IdxW'(PathSlots - 1)) begin
							state <= stService;
						end
					end
				end
				stService: begin
					state <= req.write ? stWritePath : stReturn;
				end
				stReturn: begin
					if (loadReady) begin
						state <= stWritePath;
					end
				end
				stWritePath: begin
					if (wrPick) begin
						wrLoaded <= 1'b1;
					end
					if (cmdFire) begin
						cmdSent <= 1'b1;
					end
					if (dataFire) begin
						dataSent <= 1'b1;
					end
					if (slotDone) begin
						wrLoaded <= 1'b0;
						cmdSent <= 1'b0;
						dataSent <= 1'b0;
						wrIdx <= wrIdx + 1'b1;
						if (wrIdx == IdxW'(PathSlots - 1)) begin
							state <= stIdle;
						end
					end
				end
				default: state <= stIdle;
			endcase
		end
	end

	// Request, load result and outgoing slot
	always_ff @(posedge Clock) begin
		if (reqValid && reqReady) begin
			req <= beReq;
		end
		if (state == stService) begin
			loadData <= svcSlot.data;
		end
		if (wrPick) begin
			wrSlot <= evHit ? evSlot : '0;
		end
	end

endmodule

`default_nettype wire

/* logic/oramFrontend.sv */
// Client command intake and position map with LFSR leaf remapping
// Request register toward the backend and read result return register
`timescale 1ns/1ps
`default_nettype none

module oramFrontend (
	input  logic             Clock,
	input  logic             rstN,
	input  oramPkg::oramCmdT cmd,
	input  logic             cmdValid,
	output logic             cmdReady,
	output oramPkg::dataT    dataOut,
	output logic             dataOutValid,
	input  logic             dataOutReady,
	output oramPkg::beReqT   beReq,
	output logic             reqValid,
	input  logic             reqReady,
	input  oramPkg::dataT    loadData,
	input  logic             loadValid,
	output logic             loadReady
);
	import oramPkg::*;

	leafT posMap [NumBlocks];
	logic [15:0] lfsr;
	logic lfsrFeedback;
	logic cmdFire;
	logic loadFire;

	// Only one request may wait for the backend
	assign cmdReady = !reqValid;
	assign cmdFire = cmdValid && cmdReady;

	// Output register takes a result only when empty
	assign loadReady = !dataOutValid;
	assign loadFire = loadValid && loadReady;

	// Taps 16, 14, 13, 11
	assign lfsrFeedback = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];

	// ------------------------------------------------------------------------
	// Position map, LFSR and valid flags
	// ------------------------------------------------------------------------

	always_ff @(posedge Clock or negedge rstN) begin
		if (!rstN) begin
			posMap <= '{default: '0};
			lfsr <= 16'hACE1;
			reqValid <= 1'b0;
			dataOutValid <= 1'b0;
		end else begin
			lfsr <= {lfsr[14:0], lfsrFeedback};
			// Remap at accept so a queued request sees the new leaf
			if (cmdFire) begin
				posMap[cmd.addr] <= leafT'(lfsr);
			end
			if (cmdFire) begin
				reqValid <= 1'b1;
			end else if (reqReady) begin
				reqValid <= 1'b0;
			end
			if (loadFire) begin
				dataOutValid <= 1'b1;
			end else if (dataOutReady) begin
				dataOutValid <= 1'b0;
			end
		end
	end

	// Request and result payloads
	always_ff @(posedge Clock) begin
		if (cmdFire) begin
			beReq.write <= cmd.write;
			beReq.addr <= cmd.addr;
			beReq.oldLeaf <= posMap[cmd.addr];
			beReq.newLeaf <= leafT'(lfsr);
			beReq.data <= cmd.data;
		end
		if (loadFire) begin
			dataOut <= loadData;
		end
	end

endmodule

`default_nettype wire

/* logic/pathOramTop.sv */
// Path ORAM top level with frontend, backend and read buffer instances
`timescale 1ns/1ps
`default_nettype none

module pathOramTop #(
	parameter int StashCap = 16,
	parameter int BufDepth = 8
) (
	input  logic             Clock,
	input  logic             rstN,
	input  oramPkg::oramCmdT cmd,
	input  logic             cmdValid,
	output logic             cmdReady,
	output oramPkg::dataT    dataOut,
	output logic             dataOutValid,
	input  logic             dataOutReady,
	output oramPkg::dramCmdT dramCmd,
	output logic             dramCmdValid,
	input  logic             dramCmdReady,
	input  oramPkg::slotT    dramReadData,
	input  logic             dramReadDataValid,
	output oramPkg::slotT    dramWriteData,
	output logic             dramWriteDataValid,
	input  logic             dramWriteDataReady
);
	import oramPkg::*;

	// Frontend to backend
	beReqT beReq;
	logic reqValid;
	logic reqReady;
	dataT loadData;
	logic loadValid;
	logic loadReady;

	// Read buffer to backend
	slotT bufData;
	logic bufValid;
	logic bufReady;

	oramFrontend frontend0 (
		.Clock(Clock),
		.rstN(rstN),
		.cmd(cmd),
		.cmdValid(cmdValid),
		.cmdReady(cmdReady),
		.dataOut(dataOut),
		.dataOutValid(dataOutValid),
		.dataOutReady(dataOutReady),
		.beReq(beReq),
		.reqValid(reqValid),
		.reqReady(reqReady),
		.loadData(loadData),
		.loadValid(loadValid),
		.loadReady(loadReady)
	);

	pathBackend #(
		.StashCap(StashCap)
	) backend0 (
		.Clock(Clock),
		.rstN(rstN),
		.beReq(beReq),
		.reqValid(reqValid),
		.reqReady(reqReady),
		.loadData(loadData),
		.loadValid(loadValid),
		.loadReady(loadReady),
		.bufData(bufData),
		.bufValid(bufValid),
		.bufReady(bufReady),
		.dramCmd(dramCmd),
		.dramCmdValid(dramCmdValid),
		.dramCmdReady(dramCmdReady),
		.dramWriteData(dramWriteData),
		.dramWriteDataValid(dramWriteDataValid),
		.dramWriteDataReady(dramWriteDataReady)
	);

	readBuffer #(
		.BufDepth(BufDepth)
	) readBuf0 (
		.Clock(Clock),
		.rstN(rstN),
		.inData(dramReadData),
		.inValid(dramReadDataValid),
		.outData(bufData),
		.outValid(bufValid),
		.outReady(bufReady)
	);

endmodule

`default_nettype wire

/* tests/dramModel.sv */
// Behavioral DRAM with command and write stalls and a fixed read latency
// Write data pairs with write commands in arrival order
`timescale 1ns/1ps
`default_nettype none

module dramModel #(
	parameter int ReadLatency = 4
) (
	input  logic             Clock,
	input  logic             rstN,
	input  logic             stallCmd,
	input  logic             stallWrite,
	input  oramPkg::dramCmdT dramCmd,
	input  logic             dramCmdValid,
	output logic             dramCmdReady,
	output oramPkg::slotT    dramReadData,
	output logic             dramReadDataValid,
	input  oramPkg::slotT    dramWriteData,
	input  logic             dramWriteDataValid,
	output logic             dramWriteDataReady
);
	import oramPkg::*;

	localparam int NumSlots = (2 ** OramLevels - 1) * OramZ;

	slotT mem [NumSlots];
	dramAddrT wrAddrQ [$];
	slotT wrDataQ [$];
	slotT rdDataQ [$];
	int rdDueQ [$];
	int cycle;
	dramAddrT wrAddr;

	// Stall pattern comes from the testbench random stream
	assign dramCmdReady = !stallCmd;
	assign dramWriteDataReady = !stallWrite;

	initial begin
		dramReadData = '0;
		dramReadDataValid = 1'b0;
		cycle = 0;
	end

	always @(posedge Clock) begin
		if (!rstN) begin
			for (int i = 0; i < NumSlots; i++) begin
				mem[i] = '0;
			end
			wrAddrQ.delete();
			wrDataQ.delete();
			rdDataQ.delete();
			rdDueQ.delete();
		end else begin
			cycle++;
			if (dramCmdValid && dramCmdReady) begin
				if (dramCmd.write) begin
					wrAddrQ.push_back(dramCmd.addr);
				end else begin
					rdDataQ.push_back(mem[dramCmd.addr]);
					rdDueQ.push_back(cycle + ReadLatency);
				end
			end
			if (dramWriteDataValid && dramWriteDataReady) begin
				wrDataQ.push_back(dramWriteData);
			end
			while (wrAddrQ.size() != 0 && wrDataQ.size() != 0) begin
				wrAddr = wrAddrQ.pop_front();
				mem[wrAddr] = wrDataQ.pop_front();
			end
		end
		// Read data changes just after the edge
		#1;
		if (rstN && rdDueQ.size() != 0 && rdDueQ[0] <= cycle) begin
			dramReadDataValid = 1'b1;
			dramReadData = rdDataQ.pop_front();
			void'(rdDueQ.pop_front());
		end else begin
			dramReadDataValid = 1'b0;
		end
	end

endmodule

`default_nettype wire

/* tests/pathOramAsserts.sv */
// Handshake stability assertions bound to the Path ORAM top level
`timescale 1ns/1ps
`default_nettype none

module pathOramAsserts (
	input logic             Clock,
	input logic             rstN,
	input oramPkg::dramCmdT dramCmd,
	input logic             dramCmdValid,
	input logic             dramCmdReady,
	input oramPkg::slotT    dramWriteData,
	input logic             dramWriteDataValid,
	input logic             dramWriteDataReady,
	input oramPkg::dataT    dataOut,
	input logic             dataOutValid,
	input logic             dataOutReady
);

	cmdHeld: assert property (@(posedge Clock) disable iff (!rstN)
		dramCmdValid && !dramCmdReady |=> dramCmdValid && $stable(dramCmd))
		else $error("DRAM command dropped or changed before dramCmdReady");

	writeHeld: assert property (@(posedge Clock) disable iff (!rstN)
		dramWriteDataValid && !dramWriteDataReady |=> dramWriteDataValid && $stable(dramWriteData))
		else $error("DRAM write data dropped or changed before dramWriteDataReady");

	resultHeld: assert property (@(posedge Clock) disable iff (!rstN)
		dataOutValid && !dataOutReady |=> dataOutValid && $stable(dataOut))
		else $error("Read result dropped or changed before dataOutReady");

endmodule

bind pathOramTop pathOramAsserts asserts0 (.*);

`default_nettype wire

/* tests/pathOramTb.sv */
// Testbench for the Path ORAM controller with directed tests
// Reference memory, result scoreboard, DRAM path checker and timeout
`timescale 1ns/1ps
`default_nettype none

module pathOramTb;
	import oramPkg::*;

	localparam int Seed = 23;
	localparam int DramLatency = 4;
	localparam int RandomAccesses = 200;
	localparam int PressureAccesses = 40;
	// Fresh reads, two write-then-read rounds, then the random runs
	localparam int TotalAccesses = NumBlocks + 2 * (NumBlocks + 1) + RandomAccesses
		+ PressureAccesses;
	localparam int CycleLimit = 200 * TotalAccesses;

	logic Clock;
	logic rstN;
	oramCmdT cmd;
	logic cmdValid;
	logic cmdReady;
	dataT dataOut;
	logic dataOutValid;
	logic dataOutReady;
	dramCmdT dramCmd;
	logic dramCmdValid;
	logic dramCmdReady;
	slotT dramReadData;
	logic dramReadDataValid;
	slotT dramWriteData;
	logic dramWriteDataValid;
	logic dramWriteDataReady;
	logic stallCmd;
	logic stallWrite;

	dataT refMem [NumBlocks];
	dataT expQ [$];
	dramCmdT pathCmds [$];
	dramAddrT writeAddrs [$];
	slotT writeSlots [$];
	dataT expected;
	int accessCount;
	int pathCount;
	int cycleCount;
	int failCount;
	logic runEnded;
	logic [31:0] rngState;
	logic [31:0] stallState;
	logic stallMode;
	logic pressureMode;
	int pressureLeft;

	pathOramTop dut0 (.*);

	dramModel #(
		.ReadLatency(DramLatency)
	) dram0 (.*);

	initial begin
		Clock = 1'b0;
		forever #4 Clock = ~Clock;
	end

	// ------------------------------------------------------------------------
	// Helpers
	// ------------------------------------------------------------------------

	function automatic logic [31:0] xorshift32(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	task automatic drawRandom(output logic [31:0] r);
		rngState = xorshift32(rngState);
		r = rngState;
	endtask

	task automatic failRun(input string why);
		failCount++;
		runEnded = 1'b1;
		$display("%s", why);
		$display("*** TEST FAILED ***");
		$fatal(1, "Stopped at first error");
	endtask

	task automatic checkEqual(input string name, input logic [63:0] want,
		input logic [63:0] got);
		if (got !== want) begin
			failRun($sformatf("Mismatch at %0d ns: %s expected 0x%0h, actual 0x%0h",
				$time, name, want, got));
		end
	endtask

	// Called 1 ns after an edge, returns 1 ns after the accepting edge
	task automatic issueCmd(input logic write, input addrT addr, input dataT data);
		cmd.write = write;
		cmd.addr = addr;
		cmd.data = data;
		cmdValid = 1'b1;
		@(posedge Clock);
		while (!cmdReady) begin
			@(posedge Clock);
		end
		if (write) begin
			refMem[addr] = data;
		end else begin
			expQ.push_back(refMem[addr]);
		end
		accessCount++;
		#1;
		cmdValid = 1'b0;
	endtask

	task automatic drainAccesses();
		while (expQ.size() != 0 || pathCount != accessCount || writeAddrs.size() != 0) begin
			@(posedge Clock);
			#1;
		end
	endtask

	// Eight reads root to leaf, then the same slots leaf to root
	task automatic checkPath();
		int bucket;
		int prevBucket;
		dramCmdT rd;
		dramCmdT wr;
		prevBucket = 0;
		for (int i = 0; i < PathSlots; i++) begin
			rd = pathCmds[i];
			bucket = int'(rd.addr) / OramZ;
			checkEqual("dramCmd.write on path read", 64'(0), 64'(rd.write));
			checkEqual("dramCmd.addr slot number", 64'(i % OramZ), 64'(int'(rd.addr) % OramZ));
			if (i == 0) begin
				checkEqual("dramCmd.addr root bucket", 64'(0), 64'(bucket));
			end else if (i % OramZ != 0) begin
				checkEqual("dramCmd.addr bucket", 64'(prevBucket), 64'(bucket));
			end else if (bucket != 2 * prevBucket + 1 && bucket != 2 * prevBucket + 2) begin
				failRun($sformatf("Read path broken at %0d ns: bucket %0d is no child of %0d",
					$time, bucket, prevBucket));
			end
			prevBucket = bucket;
		end
		for (int j = 0; j < PathSlots; j++) begin
			wr = pathCmds[PathSlots + j];
			rd = pathCmds[(OramLevels - 1 - j / OramZ) * OramZ + j % OramZ];
			checkEqual("dramCmd.write on path write", 64'(1), 64'(wr.write));
			checkEqual("dramCmd.addr on path write", 64'(rd.addr), 64'(wr.addr));
		end
	endtask

	// A valid block may only be written into a bucket on its own leaf's path
	task automatic verifyPlacement(input dramAddrT addr, input slotT slot);
		int bucket;
		int node;
		bucket = int'(addr) / OramZ;
		// Start at the leaf bucket and climb toward the root
		node = (1 << (OramLevels - 1)) - 1 + int'(slot.leaf);
		while (node > bucket) begin
			node = (node - 1) / 2;
		end
		if (slot.valid) begin
			checkEqual("dramWriteData.leaf bucket on path", 64'(bucket), 64'(node));
		end
	endtask

	// ------------------------------------------------------------------------
	// Directed tests
	// ------------------------------------------------------------------------

	task automatic readFreshAddresses();
		for (int a = 0; a < NumBlocks; a++) begin
			issueCmd(1'b0, addrT'(a), '0);
		end
		drainAccesses();
	endtask

	task automatic writeThenRead(input addrT target);
		logic [31:0] r;
		drawRandom(r);
		issueCmd(1'b1, target, r);
		// Every other block moves through the tree in between
		for (int a = 0; a < NumBlocks; a++) begin
			if (addrT'(a) != target) begin
				drawRandom(r);
				issueCmd(1'b1, addrT'(a), r);
			end
		end
		issueCmd(1'b0, target, '0);
		drainAccesses();
	endtask

	task automatic runRandom(input int count, input logic gaps);
		logic [31:0] r;
		logic [31:0] d;
		for (int i = 0; i < count; i++) begin
			drawRandom(r);
			drawRandom(d);
			issueCmd(r[0], addrT'(r[4:1]), d);
			if (gaps && r[7:5] == 3'd0) begin
				repeat (int'(r[10:8])) begin
					@(posedge Clock);
					#1;
				end
			end
		end
		drainAccesses();
	endtask

	task automatic randomMix();
		stallMode = 1'b1;
		runRandom(RandomAccesses, 1'b1);
		stallMode = 1'b0;
	endtask

	task automatic resultBackPressure();
		stallMode = 1'b1;
		pressureMode = 1'b1;
		runRandom(PressureAccesses, 1'b0);
		pressureMode = 1'b0;
		stallMode = 1'b0;
	endtask

	// ------------------------------------------------------------------------
	// Monitors and random ready patterns
	// ------------------------------------------------------------------------

	always @(posedge Clock) begin
		if (rstN && dataOutValid && dataOutReady) begin
			if (expQ.size() == 0) begin
				failRun("A read result arrived while no read was outstanding");
			end else begin
				expected = expQ.pop_front();
				checkEqual("dataOut", 64'(expected), 64'(dataOut));
			end
		end
	end

	always @(posedge Clock) begin
		if (rstN && dramCmdValid && dramCmdReady) begin
			pathCmds.push_back(dramCmd);
			if (pathCmds.size() == 2 * PathSlots) begin
				checkPath();
				pathCmds.delete();
				pathCount++;
			end
		end
	end

	// Write data pairs with write commands in order, as in the DRAM
	always @(posedge Clock) begin
		if (rstN && dramCmdValid && dramCmdReady && dramCmd.write) begin
			writeAddrs.push_back(dramCmd.addr);
		end
		if (rstN && dramWriteDataValid && dramWriteDataReady) begin
			writeSlots.push_back(dramWriteData);
		end
		while (writeAddrs.size() != 0 && writeSlots.size() != 0) begin
			verifyPlacement(writeAddrs.pop_front(), writeSlots.pop_front());
		end
	end

	always @(posedge Clock) begin
		cycleCount++;
		if (cycleCount > CycleLimit) begin
			failRun($sformatf("Timeout after %0d cycles, %0d accesses issued, %0d paths seen",
				cycleCount, accessCount, pathCount));
		end
	end

	always @(posedge Clock) begin
		#1;
		stallState = xorshift32(stallState);
		stallCmd = stallMode && stallState[1:0] == 2'd0;
		stallWrite = stallMode && stallState[3:2] == 2'd0;
		// Result ready held at one level for a random stretch
		if (!pressureMode) begin
			dataOutReady = 1'b1;
		end else if (pressureLeft == 0) begin
			dataOutReady = stallState[8];
			pressureLeft = int'(stallState[12:9]);
		end else begin
			pressureLeft--;
		end
	end

	initial begin
		rngState = 32'(Seed);
		stallState = xorshift32(32'(Seed));
		rstN = 1'b0;
		cmd = '0;
		cmdValid = 1'b0;
		dataOutReady = 1'b1;
		stallCmd = 1'b0;
		stallWrite = 1'b0;
		stallMode = 1'b0;
		pressureMode = 1'b0;
		pressureLeft = 0;
		accessCount = 0;
		pathCount = 0;
		cycleCount = 0;
		failCount = 0;
		runEnded = 1'b0;
		for (int a = 0; a < NumBlocks; a++) begin
			refMem[a] = '0;
		end
		repeat (3) @(posedge Clock);
		#1;
		rstN = 1'b1;
		checkEqual("cmdReady", 64'(1), 64'(cmdReady));
		checkEqual("dataOutValid", 64'(0), 64'(dataOutValid));
		checkEqual("dramCmdValid", 64'(0), 64'(dramCmdValid));
		checkEqual("dramWriteDataValid", 64'(0), 64'(dramWriteDataValid));
		readFreshAddresses();
		writeThenRead(addrT'(3));
		writeThenRead(addrT'(12));
		randomMix();
		resultBackPressure();
		if (failCount == 0) begin
			runEnded = 1'b1;
			$display("*** TEST PASSED ***");
			$finish;
		end else begin
			failRun("Errors were recorded during the run");
		end
	end

	// Run cut short by the simulator, such as a stop on a failed assertion
	final begin
		if (!runEnded) begin
			$display("*** TEST FAILED ***");
		end
	end

endmodule

`default_nettype wire

/* sources.f */
logic/oramPkg.sv
logic/readBuffer.sv
logic/oramStash.sv
logic/pathBackend.sv
logic/oramFrontend.sv
logic/pathOramTop.sv
tests/dramModel.sv
tests/pathOramAsserts.sv
tests/pathOramTb.sv

/* Makefile */
SIM      = verilator
FLAGS    = --binary --timing --assert -Wno-fatal -j 0
TOP      = pathOramTb
FILELIST = sources.f
BUILD    = obj_dir
LOG      = sim.log
FAIL_MSG = *** TEST FAILED ***
PASS_MSG = *** TEST PASSED ***

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build folder and the log"
	@echo "  help   show this list"

test:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)
	-./$(BUILD)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -qF "$(FAIL_MSG)" $(LOG); then echo "Result: FAIL"; exit 1; fi
	@if ! grep -qF "$(PASS_MSG)" $(LOG); then echo "Result: FAIL, run incomplete"; exit 1; fi
	@echo "Result: PASS"

clean:
	rm -rf $(BUILD) $(LOG)
